//--- stats_data_pkg.sv
package stats_data_pkg;

  // Which extreme a tracker follows
  // Max clears to zero, min clears to all ones
  typedef enum logic {
    KIND_MAX = 1'b0,
    KIND_MIN = 1'b1
  } extreme_kind_e;

  // Sample width
  localparam int DEF_WIDTH = 8;

  // Chunk width per tracker stage
  // Two stages with the default sample width
  localparam int DEF_BITS_PER_STAGE = 4;

  // Counter width
  // Sum is DEF_WIDTH + DEF_COUNT_WIDTH bits wide
  localparam int DEF_COUNT_WIDTH = 16;

endpackage

//--- stats_reg_pkg.sv
package stats_reg_pkg;

  // Register map of the statistics unit
  // Address 3'd7 is left unmapped and reads as zero
  typedef enum logic [2:0] {
    // Enable, read/write
    REG_CTRL   = 3'd0,
    // Clear command, write only
    REG_CMD    = 3'd1,
    // Accepted sample count
    REG_COUNT  = 3'd2,
    // Low word of the sample sum
    REG_SUM    = 3'd3,
    // Running maximum
    REG_MAX    = 3'd4,
    // Running minimum
    REG_MIN    = 3'd5,
    // Pipeline busy flag
    REG_STATUS = 3'd6
  } reg_addr_e;

  // Enable bit in REG_CTRL
  localparam int CTRL_EN_BIT = 0;

  // Clear bit in REG_CMD
  localparam int CMD_CLR_BIT = 0;

  // Busy bit in REG_STATUS
  localparam int STATUS_BUSY_BIT = 0;

endpackage

//--- stats_extreme.sv
`timescale 1ns/10ps

module stats_extreme #(
  parameter int WIDTH = 8,
  parameter int BITS_PER_STAGE = 4,
  parameter stats_data_pkg::extreme_kind_e KIND = stats_data_pkg::KIND_MAX
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             clr,
  input  logic             en,
  input  logic [WIDTH-1:0] val,
  output logic [WIDTH-1:0] extreme,
  output logic             busy
);

  localparam int STAGES = WIDTH / BITS_PER_STAGE;
  localparam int CHUNK = BITS_PER_STAGE;
  localparam bit IS_MAX = (KIND == stats_data_pkg::KIND_MAX);
  // Empty result, the worst possible value for this kind
  localparam logic [WIDTH-1:0] CLR_VAL = IS_MAX ? {WIDTH{1'b0}} : {WIDTH{1'b1}};

  if (STAGES == 1) begin : g_direct
    // Whole-word compare, result moves at the accepting edge
    always_ff @(posedge clk) begin
      if (!rst_n || clr) begin
        extreme <= CLR_VAL;
      end else if (en) begin
        if (IS_MAX ? (val > extreme) : (val < extreme)) begin
          extreme <= val;
        end
      end
    end

    // Nothing is ever in flight
    assign busy = 1'b0;

  end else begin : g_pipe
    // Per-item decision, carried from the MS chunk downwards
    typedef enum logic [1:0] {CMP_EQ, CMP_CAND, CMP_HELD} cmp_state_e;

    localparam logic [CHUNK-1:0] CLR_CHUNK = CLR_VAL[CHUNK-1:0];

    // Input register
    logic             in_valid;
    logic [WIDTH-1:0] in_val;

    // Stage output registers, one item per stage
    logic [STAGES-1:0] st_valid;
    cmp_state_e        st_state [STAGES];
    logic [WIDTH-1:0]  st_cand  [STAGES];
    logic [WIDTH-1:0]  st_res   [STAGES];

    // Chunk k of the running result, owned by stage k
    logic [CHUNK-1:0] chunk_q [STAGES];

    // Stage inputs and next values
    logic [STAGES-1:0] src_valid;
    cmp_state_e        src_state [STAGES];
    logic [WIDTH-1:0]  src_cand  [STAGES];
    logic [WIDTH-1:0]  src_res   [STAGES];
    cmp_state_e        nxt_state [STAGES];
    logic [CHUNK-1:0]  win_chunk [STAGES];
    logic [WIDTH-1:0]  nxt_res   [STAGES];

    for (genvar k = 0; k < STAGES; k++) begin : g_stage
      // Stage 0 handles the top chunk
      localparam int LSB = WIDTH - (k + 1) * CHUNK;

      logic [CHUNK-1:0] cand_chunk;
      logic             cand_wins;
      logic             held_wins;

      if (k == 0) begin : g_head
        // Fresh item, nothing decided yet
        assign src_valid[k] = in_valid;
        assign src_state[k] = CMP_EQ;
        assign src_cand[k]  = in_val;
        assign src_res[k]   = '0;
      end else begin : g_body
        assign src_valid[k] = st_valid[k-1];
        assign src_state[k] = st_state[k-1];
        assign src_cand[k]  = st_cand[k-1];
        assign src_res[k]   = st_res[k-1];
      end

      assign cand_chunk = src_cand[k][LSB +: CHUNK];
      assign cand_wins  = IS_MAX ? (cand_chunk > chunk_q[k]) : (cand_chunk < chunk_q[k]);
      assign held_wins  = IS_MAX ? (cand_chunk < chunk_q[k]) : (cand_chunk > chunk_q[k]);

      // Only a tie so far lets this chunk decide
      assign nxt_state[k] = (src_state[k] != CMP_EQ) ? src_state[k] :
                            cand_wins ? CMP_CAND :
                            held_wins ? CMP_HELD : CMP_EQ;

      // On a tie both chunks match, so the held one serves
      assign win_chunk[k] = (nxt_state[k] == CMP_CAND) ? cand_chunk : chunk_q[k];
      assign nxt_res[k]   = src_res[k] | (WIDTH'(win_chunk[k]) << LSB);
    end

    // Valid bits, chunk registers and output
    always_ff @(posedge clk) begin
      if (!rst_n || clr) begin
        in_valid <= 1'b0;
        st_valid <= '0;
        for (int k = 0; k < STAGES; k++) begin
          chunk_q[k] <= CLR_CHUNK;
        end
        extreme <= CLR_VAL;
      end else begin
        in_valid <= en;
        for (int k = 0; k < STAGES; k++) begin
          st_valid[k] <= src_valid[k];
          // Write back so the next item compares against this one
          if (src_valid[k]) begin
            chunk_q[k] <= win_chunk[k];
          end
        end
        // Last stage holds the complete result
        if (st_valid[STAGES-1]) begin
          extreme <= st_res[STAGES-1];
        end
      end
    end

    // Item payload, qualified by the valid bits
    always_ff @(posedge clk) begin
      in_val <= val;
      for (int k = 0; k < STAGES; k++) begin
        st_state[k] <= nxt_state[k];
        st_cand[k]  <= src_cand[k];
        st_res[k]   <= nxt_res[k];
      end
    end

    assign busy = in_valid | (|st_valid);
  end

  // Chunks must tile the sample exactly
  a_chunk_tiles: assert property (@(posedge clk) (WIDTH % BITS_PER_STAGE) == 0)
    else $error("BITS_PER_STAGE does not divide WIDTH");

  // Result only moves towards the extreme between clears
  a_monotonic: assert property (@(posedge clk) disable iff (!rst_n)
    $past(rst_n) && !$past(clr) |->
      (IS_MAX ? (extreme >= $past(extreme)) : (extreme <= $past(extreme))))
    else $error("Extreme moved the wrong way");

endmodule

//--- stats_accum.sv
`timescale 1ns/10ps

module stats_accum #(
  parameter int WIDTH = 8,
  parameter int COUNT_WIDTH = 16
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         clr,
  input  logic                         en,
  input  logic [WIDTH-1:0]             val,
  output logic [COUNT_WIDTH-1:0]       count,
  output logic [WIDTH+COUNT_WIDTH-1:0] sum
);

  // Wide enough for a full count of maximum samples
  localparam int SUM_WIDTH = WIDTH + COUNT_WIDTH;

  logic count_full;

  // Count stuck at all ones
  assign count_full = &count;

  // Count and sum move together
  // Once the count is full the sum is frozen too, so it cannot wrap
  always_ff @(posedge clk) begin
    if (!rst_n || clr) begin
      count <= '0;
      sum   <= '0;
    end else if (en && !count_full) begin
      count <= count + 1'b1;
      sum   <= sum + SUM_WIDTH'(val);
    end
  end

  // Count only goes down through clear or reset
  a_count_monotonic: assert property (@(posedge clk) disable iff (!rst_n)
    $past(rst_n) && !$past(clr) |-> (count >= $past(count)))
    else $error("Sample count dropped without clear");

endmodule

//--- stats_regs.sv
`timescale 1ns/10ps

module stats_regs #(
  parameter int WIDTH = 8,
  parameter int COUNT_WIDTH = 16
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         reg_wr,
  input  logic                         reg_rd,
  input  stats_reg_pkg::reg_addr_e     reg_addr,
  input  logic [31:0]                  reg_wdata,
  output logic [31:0]                  reg_rdata,
  input  logic                         sample_valid,
  output logic                         sample_en,
  output logic                         clr,
  input  logic [WIDTH-1:0]             max_val,
  input  logic [WIDTH-1:0]             min_val,
  input  logic [COUNT_WIDTH-1:0]       count,
  input  logic [WIDTH+COUNT_WIDTH-1:0] sum,
  input  logic                         busy
);

  logic        en_q;
  logic        wr_ctrl;
  logic        wr_cmd;
  logic [31:0] ctrl_word;
  logic [31:0] status_word;
  logic [31:0] rd_word;

  // Write decode
  assign wr_ctrl = reg_wr && (reg_addr == stats_reg_pkg::REG_CTRL);
  assign wr_cmd  = reg_wr && (reg_addr == stats_reg_pkg::REG_CMD);

  // New enable value applies to samples from the next cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      en_q <= 1'b0;
    end else if (wr_ctrl) begin
      en_q <= reg_wdata[stats_reg_pkg::CTRL_EN_BIT];
    end
  end

  // Clear strobe lasts exactly the write cycle
  // Datapath clears at the same edge as the write
  assign clr = wr_cmd && reg_wdata[stats_reg_pkg::CMD_CLR_BIT];

  // Samples pass only while enabled
  assign sample_en = sample_valid && en_q;

  // Single-bit registers placed at their field positions
  assign ctrl_word   = 32'(en_q) << stats_reg_pkg::CTRL_EN_BIT;
  assign status_word = 32'(busy) << stats_reg_pkg::STATUS_BUSY_BIT;

  // Read mux zero-extends narrower values
  always_comb begin
    case (reg_addr)
      stats_reg_pkg::REG_CTRL:   rd_word = ctrl_word;
      stats_reg_pkg::REG_COUNT:  rd_word = 32'(count);
      // Low word only
      stats_reg_pkg::REG_SUM:    rd_word = 32'(sum);
      stats_reg_pkg::REG_MAX:    rd_word = 32'(max_val);
      stats_reg_pkg::REG_MIN:    rd_word = 32'(min_val);
      stats_reg_pkg::REG_STATUS: rd_word = status_word;
      // Command register and unmapped space read as zero
      default:                   rd_word = '0;
    endcase
  end

  // Read data is registered and valid the cycle after reg_rd
  // Holds its last value between reads
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      reg_rdata <= '0;
    end else if (reg_rd) begin
      reg_rdata <= rd_word;
    end
  end

  // Bus carries one access per cycle
  a_no_wr_rd: assert property (@(posedge clk) disable iff (!rst_n)
    !(reg_wr && reg_rd))
    else $error("Register write and read in the same cycle");

endmodule

//--- stats_top.sv
`timescale 1ns/10ps

module stats_top #(
  parameter int WIDTH = stats_data_pkg::DEF_WIDTH,
  parameter int BITS_PER_STAGE = stats_data_pkg::DEF_BITS_PER_STAGE,
  parameter int COUNT_WIDTH = stats_data_pkg::DEF_COUNT_WIDTH
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     sample_valid,
  input  logic [WIDTH-1:0]         sample,
  input  logic                     reg_wr,
  input  logic                     reg_rd,
  input  stats_reg_pkg::reg_addr_e reg_addr,
  input  logic [31:0]              reg_wdata,
  output logic [31:0]              reg_rdata
);

  // Datapath control from the register block
  logic sample_en;
  logic clr;

  // Statistics back to the register block
  logic [WIDTH-1:0]             max_val;
  logic [WIDTH-1:0]             min_val;
  logic [COUNT_WIDTH-1:0]       count;
  logic [WIDTH+COUNT_WIDTH-1:0] sum;
  logic                         max_busy;
  logic                         min_busy;
  logic                         busy;

  // Busy while either tracker has items in flight
  assign busy = max_busy | min_busy;

  stats_regs #(
    .WIDTH       (WIDTH),
    .COUNT_WIDTH (COUNT_WIDTH)
  ) regs_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .reg_wr       (reg_wr),
    .reg_rd       (reg_rd),
    .reg_addr     (reg_addr),
    .reg_wdata    (reg_wdata),
    .reg_rdata    (reg_rdata),
    .sample_valid (sample_valid),
    .sample_en    (sample_en),
    .clr          (clr),
    .max_val      (max_val),
    .min_val      (min_val),
    .count        (count),
    .sum          (sum),
    .busy         (busy)
  );

  // Running maximum
  stats_extreme #(
    .WIDTH          (WIDTH),
    .BITS_PER_STAGE (BITS_PER_STAGE),
    .KIND           (stats_data_pkg::KIND_MAX)
  ) max_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .clr     (clr),
    .en      (sample_en),
    .val     (sample),
    .extreme (max_val),
    .busy    (max_busy)
  );

  // Running minimum
  stats_extreme #(
    .WIDTH          (WIDTH),
    .BITS_PER_STAGE (BITS_PER_STAGE),
    .KIND           (stats_data_pkg::KIND_MIN)
  ) min_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .clr     (clr),
    .en      (sample_en),
    .val     (sample),
    .extreme (min_val),
    .busy    (min_busy)
  );

  stats_accum #(
    .WIDTH       (WIDTH),
    .COUNT_WIDTH (COUNT_WIDTH)
  ) accum_i (
    .clk   (clk),
    .rst_n (rst_n),
    .clr   (clr),
    .en    (sample_en),
    .val   (sample),
    .count (count),
    .sum   (sum)
  );

endmodule

//--- stats_checker.sv
`timescale 1ns/10ps

module stats_checker #(
  parameter int WIDTH = 8,
  parameter int BITS_PER_STAGE = 4,
  parameter int COUNT_WIDTH = 16
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     sample_valid,
  input  logic [WIDTH-1:0]         sample,
  input  logic                     reg_wr,
  input  logic                     reg_rd,
  input  stats_reg_pkg::reg_addr_e reg_addr,
  input  logic [31:0]              reg_wdata,
  input  logic [31:0]              reg_rdata,
  output int                       error_count,
  output int                       check_count
);

  // Cycles from the accepting edge until the tracker output settles
  localparam int LATENCY = WIDTH / BITS_PER_STAGE + 1;
  localparam int SUM_WIDTH = WIDTH + COUNT_WIDTH;

  // Samples accepted since the last clear or reset
  logic [WIDTH-1:0]         accepted [$];
  logic                     en_ref;
  // Edges left until the last accepted sample leaves the trackers
  int                       flight;
  logic                     rd_pending;
  stats_reg_pkg::reg_addr_e rd_addr;
  logic [31:0]              rd_expect;
  logic                     clr_now;

  // Expected register contents from the accepted samples
  function automatic logic [31:0] expected_value(input stats_reg_pkg::reg_addr_e addr);
    logic [WIDTH-1:0] max_v;
    logic [WIDTH-1:0] min_v;
    longint unsigned  n;
    longint unsigned  total;
    longint unsigned  n_limit;
    logic [31:0]      result;
    max_v = '0;
    min_v = '1;
    n = 0;
    total = 0;
    n_limit = (64'd1 << COUNT_WIDTH) - 1;
    foreach (accepted[i]) begin
      if (accepted[i] > max_v) begin
        max_v = accepted[i];
      end
      if (accepted[i] < min_v) begin
        min_v = accepted[i];
      end
      // Count saturates and the sum freezes with it
      if (n < n_limit) begin
        n = n + 1;
        total = total + accepted[i];
      end
    end
    case (addr)
      stats_reg_pkg::REG_CTRL:   result = 32'(en_ref) << stats_reg_pkg::CTRL_EN_BIT;
      stats_reg_pkg::REG_COUNT:  result = 32'(n);
      stats_reg_pkg::REG_SUM:    result = 32'(total & ((64'd1 << SUM_WIDTH) - 1));
      stats_reg_pkg::REG_MAX:    result = 32'(max_v);
      stats_reg_pkg::REG_MIN:    result = 32'(min_v);
      stats_reg_pkg::REG_STATUS: result = 32'(flight > 0) << stats_reg_pkg::STATUS_BUSY_BIT;
      default:                   result = '0;
    endcase
    return result;
  endfunction

  always @(posedge clk) begin
    if (!rst_n) begin
      accepted.delete();
      en_ref = 1'b0;
      flight = 0;
      rd_pending = 1'b0;
      error_count = 0;
      check_count = 0;
    end else begin
      // Read data captured at the previous edge is stable here
      if (rd_pending) begin
        check_count = check_count + 1;
        if (reg_rdata !== rd_expect) begin
          error_count = error_count + 1;
          $display("Mismatch at %0d ns: %s expected 0x%08h, got 0x%08h",
                   $time, rd_addr.name(), rd_expect, reg_rdata);
        end
      end
      // Expectation uses the state before this edge
      rd_pending = reg_rd;
      if (reg_rd) begin
        rd_addr = reg_addr;
        rd_expect = expected_value(reg_addr);
      end
      clr_now = reg_wr && (reg_addr == stats_reg_pkg::REG_CMD) &&
                reg_wdata[stats_reg_pkg::CMD_CLR_BIT];
      // A sample in the clear cycle is dropped
      if (clr_now) begin
        accepted.delete();
        flight = 0;
      end else if (sample_valid && en_ref) begin
        accepted.push_back(sample);
        flight = LATENCY;
      end else if (flight > 0) begin
        flight = flight - 1;
      end
      // Enable applies from the next cycle
      if (reg_wr && (reg_addr == stats_reg_pkg::REG_CTRL)) begin
        en_ref = reg_wdata[stats_reg_pkg::CTRL_EN_BIT];
      end
    end
  end

endmodule

//--- tb_stats_top.sv
`timescale 1ns/10ps

module tb_stats_top;

  localparam int WIDTH = stats_data_pkg::DEF_WIDTH;
  localparam int BITS_PER_STAGE = stats_data_pkg::DEF_BITS_PER_STAGE;
  localparam int COUNT_WIDTH = stats_data_pkg::DEF_COUNT_WIDTH;
  // Roughly 400 samples at up to four cycles each, register traffic and margin
  localparam int MAX_CYCLES = 4000;

  logic                     clk;
  logic                     rst_n;
  logic                     sample_valid;
  logic [WIDTH-1:0]         sample;
  logic                     reg_wr;
  logic                     reg_rd;
  stats_reg_pkg::reg_addr_e reg_addr;
  logic [31:0]              reg_wdata;
  logic [31:0]              reg_rdata;
  int                       error_count;
  int                       check_count;
  int                       cycle_count;
  logic [31:0]              rd_data;

  // Directed values, larger, smaller and both ends of the range
  logic [WIDTH-1:0] single_vals [5] = '{8'h40, 8'h90, 8'h15, 8'h00, 8'hFF};

  stats_top #(
    .WIDTH          (WIDTH),
    .BITS_PER_STAGE (BITS_PER_STAGE),
    .COUNT_WIDTH    (COUNT_WIDTH)
  ) dut_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .sample_valid (sample_valid),
    .sample       (sample),
    .reg_wr       (reg_wr),
    .reg_rd       (reg_rd),
    .reg_addr     (reg_addr),
    .reg_wdata    (reg_wdata),
    .reg_rdata    (reg_rdata)
  );

  stats_checker #(
    .WIDTH          (WIDTH),
    .BITS_PER_STAGE (BITS_PER_STAGE),
    .COUNT_WIDTH    (COUNT_WIDTH)
  ) checker_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .sample_valid (sample_valid),
    .sample       (sample),
    .reg_wr       (reg_wr),
    .reg_rd       (reg_rd),
    .reg_addr     (reg_addr),
    .reg_wdata    (reg_wdata),
    .reg_rdata    (reg_rdata),
    .error_count  (error_count),
    .check_count  (check_count)
  );

  always #20 clk = ~clk;

  // Run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles, %0d errors so far",
               MAX_CYCLES, error_count);
      $display("*** FAILED ***");
      $finish;
    end
  end

  task automatic write_reg(input stats_reg_pkg::reg_addr_e addr, input logic [31:0] data);
    @(posedge clk);
    reg_wr    <= 1'b1;
    reg_addr  <= addr;
    reg_wdata <= data;
    @(posedge clk);
    reg_wr <= 1'b0;
  endtask

  task automatic read_reg(input stats_reg_pkg::reg_addr_e addr, output logic [31:0] data);
    @(posedge clk);
    reg_rd   <= 1'b1;
    reg_addr <= addr;
    @(posedge clk);
    reg_rd <= 1'b0;
    // Data was registered at the previous edge
    @(posedge clk);
    data = reg_rdata;
  endtask

  // Poll the busy flag until the trackers drain
  task automatic wait_idle();
    logic [31:0] status;
    status = 32'h1 << stats_reg_pkg::STATUS_BUSY_BIT;
    while (status[stats_reg_pkg::STATUS_BUSY_BIT]) begin
      read_reg(stats_reg_pkg::REG_STATUS, status);
    end
  endtask

  task automatic read_stats();
    read_reg(stats_reg_pkg::REG_CTRL, rd_data);
    read_reg(stats_reg_pkg::REG_COUNT, rd_data);
    read_reg(stats_reg_pkg::REG_SUM, rd_data);
    read_reg(stats_reg_pkg::REG_MAX, rd_data);
    read_reg(stats_reg_pkg::REG_MIN, rd_data);
  endtask

  task automatic send_one(input logic [WIDTH-1:0] value);
    @(posedge clk);
    sample_valid <= 1'b1;
    sample       <= value;
    @(posedge clk);
    sample_valid <= 1'b0;
  endtask

  // Random samples, valid high about three cycles in four
  task automatic send_stream(input int n_samples);
    int   sent;
    logic valid_bit;
    sent = 0;
    while (sent < n_samples) begin
      @(posedge clk);
      valid_bit = (($urandom % 4) != 0);
      sample_valid <= valid_bit;
      sample       <= WIDTH'($urandom);
      if (valid_bit) begin
        sent = sent + 1;
      end
    end
    @(posedge clk);
    sample_valid <= 1'b0;
  endtask

  initial begin
    void'($urandom(32'h2b87));
    clk          = 1'b0;
    rst_n        = 1'b0;
    sample_valid = 1'b0;
    sample       = '0;
    reg_wr       = 1'b0;
    reg_rd       = 1'b0;
    reg_addr     = stats_reg_pkg::REG_CTRL;
    reg_wdata    = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    // Reset values
    read_stats();
    read_reg(stats_reg_pkg::REG_STATUS, rd_data);

    // Disabled input is ignored
    send_stream(20);
    wait_idle();
    read_reg(stats_reg_pkg::REG_COUNT, rd_data);

    // Single samples with idle gaps
    write_reg(stats_reg_pkg::REG_CTRL, 32'h1 << stats_reg_pkg::CTRL_EN_BIT);
    foreach (single_vals[i]) begin
      send_one(single_vals[i]);
      wait_idle();
      read_reg(stats_reg_pkg::REG_MAX, rd_data);
      read_reg(stats_reg_pkg::REG_MIN, rd_data);
    end
    read_stats();

    // Back-to-back bursts, several items in flight
    repeat (3) begin
      send_stream(50);
      wait_idle();
      read_stats();
    end

    // Clear while idle, then a fresh stream
    write_reg(stats_reg_pkg::REG_CMD, 32'h1 << stats_reg_pkg::CMD_CLR_BIT);
    read_stats();
    send_stream(50);
    wait_idle();
    read_stats();

    // Clear with items still in the trackers
    send_stream(30);
    write_reg(stats_reg_pkg::REG_CMD, 32'h1 << stats_reg_pkg::CMD_CLR_BIT);
    wait_idle();
    read_stats();
    send_stream(40);
    wait_idle();
    read_stats();

    // Enable toggled in the middle of a stream
    fork
      send_stream(80);
      begin
        repeat (15) @(posedge clk);
        write_reg(stats_reg_pkg::REG_CTRL, 32'h0);
        repeat (20) @(posedge clk);
        write_reg(stats_reg_pkg::REG_CTRL, 32'h1 << stats_reg_pkg::CTRL_EN_BIT);
      end
    join
    wait_idle();
    read_stats();

    repeat (2) @(posedge clk);
    $display("Register checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0 && check_count > 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- vlog.f
stats_data_pkg.sv
stats_reg_pkg.sv
stats_extreme.sv
stats_accum.sv
stats_regs.sv
stats_top.sv
stats_checker.sv
tb_stats_top.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the statistics unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_stats_top -f vlog.f \
  || { echo "Build failed"; exit 1; }
out="$(./obj_dir/Vtb_stats_top)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qF '*** PASSED ***' && exit 0 || exit 1
